// File: list.f
src/core_pkg.sv
src/fetch_stage.sv
src/lane_decode.sv
src/scoreboard.sv
src/regfile.sv
src/lane_alu.sv
src/core_top.sv
tb/core_assertions.sv
tb/core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f list.f -o core_sim
status=0
./obj_dir/core_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -qF '** FAIL **' sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: tb/core_tb.sv
module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk       = 1'b0;
  logic        reset     = 1'b1;
  logic        ic_ready  = 1'b0;
  logic [63:0] ic_packet = '0;
  logic        ic_valid, wb_valid, wb_we0, wb_we1;
  logic [15:0] ic_addr, wb_pc;
  logic [4:0]  wb_rd_num0, wb_rd_num1;
  logic [31:0] wb_rd_data0, wb_rd_data1;

  logic [63:0] mem [256];
  logic [31:0] ref_regs [32];
  logic [15:0] seen_pc [$];
  int          seed   = 34470;
  int          delay  = 0;
  int          errors = 0;
  int          tests  = 0;

  core_top dut0 (
    .clkrst_core_clk(clk), .reset, .ic_valid, .ic_addr, .ic_ready, .ic_packet,
    .wb_valid, .wb_pc, .wb_we0, .wb_we1, .wb_rd_num0, .wb_rd_data0,
    .wb_rd_num1, .wb_rd_data1
  );

  always #5 clk = ~clk;

  // Instruction memory with 0 to 3 wait cycles per request
  always @(posedge clk) begin
    #1;
    if (ic_ready) begin
      ic_ready = 1'b0;                    // Accepted at this edge
      delay = {$random(seed)} % 4;
    end else if (ic_valid) begin
      if (delay == 0) begin
        ic_ready  = 1'b1;
        ic_packet = mem[ic_addr[7:0]];
      end else begin
        delay--;
      end
    end
  end

  function automatic logic [31:0] reg_instr(input logic [3:0] op, input int rd, rs, rt);
    core_pkg::instr_t w;
    w = '0;
    w.reg_form.opcode = op;
    w.reg_form.rd = 5'(rd);
    w.reg_form.rs = 5'(rs);
    w.reg_form.rt = 5'(rt);
    return w;
  endfunction

  function automatic logic [31:0] imm_instr(input logic [3:0] op, input int rd, rs, imm);
    core_pkg::instr_t w;
    w = '0;
    w.imm_form.opcode = op;
    w.imm_form.rd = 5'(rd);
    w.imm_form.rs = 5'(rs);
    w.imm_form.imm = 18'(imm);
    return w;
  endfunction

  task automatic clear_mem();
    for (int a = 0; a < 256; a++)
      mem[a] = {32'(a) << 1, 32'(a)};     // Nop words whose tail carries the address
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got, exp);
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic log_result(input string name, input int errs_before);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic reset_core();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  // One lane of the reference model, reading the state from before the bundle
  task automatic model_lane(input logic [31:0] word, input logic lane0, input logic [15:0] pc,
                            output logic we, output logic [4:0] rd, output logic [31:0] data,
                            output logic br, output logic [15:0] target);
    core_pkg::instr_t w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    w = word;
    a = ref_regs[w.reg_form.rs];
    b = ref_regs[w.reg_form.rt];
    imm = {{14{w.imm_form.imm[17]}}, w.imm_form.imm};
    rd = w.reg_form.rd;
    we = 1'b1;
    br = 1'b0;
    target = pc + imm[15:0];
    case (w.reg_form.opcode)
      core_pkg::op_add:  data = a + b;
      core_pkg::op_sub:  data = a - b;
      core_pkg::op_and:  data = a & b;
      core_pkg::op_or:   data = a | b;
      core_pkg::op_xor:  data = a ^ b;
      core_pkg::op_addi: data = a + imm;
      core_pkg::op_shli: data = a << imm[4:0];
      core_pkg::op_br: begin
        we = lane0;                       // Lane 1 branch is a nop
        br = lane0;
        data = {16'h0, pc + 16'd1};       // Link value
      end
      default: begin
        we = 1'b0;
        data = '0;
      end
    endcase
  endtask

  task automatic run_program(input int n_commits);
    logic [15:0] pc, t0, t1;
    logic [63:0] b;
    logic we0, we1, br0, br1;
    logic [4:0]  rd0, rd1;
    logic [31:0] d0, d1;
    int cyc;
    for (int r = 0; r < 32; r++)
      ref_regs[r] = '0;
    seen_pc.delete();
    pc = '0;
    reset_core();
    for (int i = 0; i < n_commits; i++) begin
      cyc = 0;
      do begin
        @(negedge clk);
        cyc++;
      end while (!wb_valid && cyc < 100);
      if (!wb_valid) begin
        $display("Timeout: commit %0d never arrived", i);
        errors++;
        return;
      end
      b = mem[pc[7:0]];
      model_lane(b[31:0], 1'b1, pc, we0, rd0, d0, br0, t0);
      model_lane(b[63:32], 1'b0, pc, we1, rd1, d1, br1, t1);
      seen_pc.push_back(wb_pc);
      assert (wb_pc == pc) else report_mismatch("wb_pc", 32'(wb_pc), 32'(pc));
      assert (wb_we0 == we0) else report_mismatch("wb_we0", 32'(wb_we0), 32'(we0));
      assert (wb_we1 == we1) else report_mismatch("wb_we1", 32'(wb_we1), 32'(we1));
      if (we0) begin
        assert (wb_rd_num0 == rd0) else report_mismatch("wb_rd_num0", 32'(wb_rd_num0), 32'(rd0));
        assert (wb_rd_data0 == d0) else report_mismatch("wb_rd_data0", wb_rd_data0, d0);
      end
      if (we1) begin
        assert (wb_rd_num1 == rd1) else report_mismatch("wb_rd_num1", 32'(wb_rd_num1), 32'(rd1));
        assert (wb_rd_data1 == d1) else report_mismatch("wb_rd_data1", wb_rd_data1, d1);
      end
      if (we0)
        ref_regs[rd0] = d0;
      if (we1)
        ref_regs[rd1] = d1;               // Lane 1 wins on the same rd
      pc = br0 ? t0 : pc + 16'd1;
    end
  endtask

  task automatic first_fetch_after_reset();
    int errs_before;
    int cyc;
    logic seen_req;
    errs_before = errors;
    clear_mem();
    reset_core();
    seen_req = 1'b0;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
      assert (!wb_valid) else report_mismatch("wb_valid before first accept", 32'(wb_valid), 0);
      if (ic_valid && !seen_req) begin
        seen_req = 1'b1;
        assert (ic_addr == 0) else report_mismatch("first ic_addr", 32'(ic_addr), 0);
      end
    end while (!(ic_valid && ic_ready) && cyc < 50);
    if (!(ic_valid && ic_ready)) begin
      $display("Timeout: the first instruction request was never accepted");
      errors++;
    end
    log_result("reset and first fetch", errs_before);
  endtask

  task automatic alu_ops_both_lanes();
    int errs_before;
    errs_before = errors;
    clear_mem();
    mem[0] = {imm_instr(core_pkg::op_addi, 2, 0, -37), imm_instr(core_pkg::op_addi, 1, 0, 100)};
    mem[1] = {reg_instr(core_pkg::op_sub, 4, 1, 2), reg_instr(core_pkg::op_add, 3, 1, 2)};
    mem[2] = {reg_instr(core_pkg::op_or, 6, 1, 2), reg_instr(core_pkg::op_and, 5, 1, 2)};
    mem[3] = {imm_instr(core_pkg::op_shli, 8, 1, 5), reg_instr(core_pkg::op_xor, 7, 1, 2)};
    mem[4] = {reg_instr(core_pkg::op_add, 9, 1, 2), reg_instr(core_pkg::op_or, 10, 2, 1)};
    mem[5] = {reg_instr(core_pkg::op_and, 11, 2, 1), imm_instr(core_pkg::op_shli, 12, 2, 3)};
    run_program(7);
    log_result("ALU operations", errs_before);
  endtask

  task automatic same_bundle_order();
    int errs_before;
    errs_before = errors;
    clear_mem();
    mem[0] = {imm_instr(core_pkg::op_addi, 2, 0, 3), imm_instr(core_pkg::op_addi, 1, 0, 7)};
    mem[1] = {reg_instr(core_pkg::op_add, 3, 1, 2), imm_instr(core_pkg::op_addi, 1, 1, 10)};
    mem[2] = {imm_instr(core_pkg::op_addi, 4, 0, 2), imm_instr(core_pkg::op_addi, 4, 0, 1)};
    mem[3] = {32'h0, reg_instr(core_pkg::op_add, 5, 4, 0)};
    run_program(5);
    log_result("bundle read order and same rd", errs_before);
  endtask

  task automatic dependent_bundles();
    int errs_before;
    errs_before = errors;
    clear_mem();
    mem[0] = {imm_instr(core_pkg::op_addi, 2, 0, 6), imm_instr(core_pkg::op_addi, 1, 0, 5)};
    mem[1] = {imm_instr(core_pkg::op_shli, 4, 1, 3), reg_instr(core_pkg::op_add, 3, 1, 2)};
    mem[2] = {reg_instr(core_pkg::op_xor, 6, 3, 1), reg_instr(core_pkg::op_sub, 5, 3, 4)};
    mem[3] = {reg_instr(core_pkg::op_or, 8, 6, 4), imm_instr(core_pkg::op_addi, 7, 5, -1)};
    run_program(6);
    log_result("back-to-back dependency", errs_before);
  endtask

  task automatic branch_flush();
    int errs_before;
    errs_before = errors;
    clear_mem();
    mem[0] = {32'h0, imm_instr(core_pkg::op_addi, 1, 0, 9)};
    mem[1] = {imm_instr(core_pkg::op_addi, 3, 0, 1), imm_instr(core_pkg::op_br, 2, 0, 3)};
    mem[2] = {32'h0, imm_instr(core_pkg::op_addi, 1, 1, 100)};   // Skipped
    mem[3] = {32'h0, imm_instr(core_pkg::op_addi, 1, 1, 200)};   // Skipped
    mem[4] = {32'h0, reg_instr(core_pkg::op_add, 4, 1, 2)};
    run_program(5);
    foreach (seen_pc[i])
      assert (seen_pc[i] != 2 && seen_pc[i] != 3) else begin
        $display("CHECK FAILED at %0t ns: bundle at skipped address %0d committed",
                 $time, seen_pc[i]);
        errors++;
      end
    log_result("branch and flush", errs_before);
  endtask

  initial begin
    first_fetch_after_reset();
    alu_ops_both_lanes();
    same_bundle_order();
    dependent_bundles();
    branch_flush();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: tb/core_assertions.sv
module core_assertions (
  input logic                       clkrst_core_clk,
  input logic                       reset,
  input logic                       ic_valid,
  input logic                       ic_ready,
  input logic [core_pkg::pc_w-1:0]  ic_addr,
  input logic                       wb_valid,
  input logic                       wb_we0,
  input logic                       wb_we1
);
  timeunit 1ns;
  timeprecision 1ps;

  // A waiting request keeps its address until ic_ready
  ic_addr_held: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    ic_valid && !ic_ready |=> ic_valid && $stable(ic_addr))
    else $error("ic_addr or ic_valid changed before ic_ready");

  no_commit_in_reset: assert property (@(posedge clkrst_core_clk)
    reset |=> !wb_valid)
    else $error("wb_valid high during reset");

  we_needs_valid: assert property (@(posedge clkrst_core_clk) disable iff (reset)
    !wb_valid |-> !wb_we0 && !wb_we1)
    else $error("write enable on the commit port without wb_valid");

endmodule

bind core_top core_assertions asrt0 (
  .clkrst_core_clk, .reset, .ic_valid, .ic_ready, .ic_addr, .wb_valid, .wb_we0, .wb_we1
);

// File: src/core_top.sv
module core_top (
  input  logic                          clkrst_core_clk,
  input  logic                          reset,
  output logic                          ic_valid,
  output logic [core_pkg::pc_w-1:0]      ic_addr,
  input  logic                          ic_ready,
  input  logic [core_pkg::bundle_w-1:0]  ic_packet,
  output logic                          wb_valid,
  output logic [core_pkg::pc_w-1:0]      wb_pc,
  output logic                          wb_we0,
  output logic                          wb_we1,
  output logic [core_pkg::reg_num_w-1:0] wb_rd_num0,
  output logic [core_pkg::data_w-1:0]    wb_rd_data0,
  output logic [core_pkg::reg_num_w-1:0] wb_rd_num1,
  output logic [core_pkg::data_w-1:0]    wb_rd_data1
);

  localparam int dw = core_pkg::data_w;
  localparam int rw = core_pkg::reg_num_w;
  localparam int pw = core_pkg::pc_w;

  logic                      bundle_valid;
  logic [core_pkg::bundle_w-1:0] bundle;
  logic [pw-1:0]             bundle_pc;
  logic                      issue;
  logic                      flush;
  logic                      dep_stall;
  logic [pw-1:0]             new_pc;

  core_pkg::alu_op_t dec_alu_op0, dec_alu_op1;
  logic [rw-1:0]     rd_num0, rs_num0, rt_num0;
  logic [rw-1:0]     rd_num1, rs_num1, rt_num1;
  logic              uses_rt0, uses_rt1, rd_we0, rd_we1, dec_branch0;
  logic [dw-1:0]     dec_imm0, dec_imm1;
  logic [dw-1:0]     rs_data0, rt_data0, rs_data1, rt_data1;

  logic              ex_valid, ex_branch, ex_rd_we0, ex_rd_we1;
  logic [pw-1:0]     ex_pc, link_pc;
  core_pkg::alu_op_t ex_alu_op0, ex_alu_op1;
  logic [dw-1:0]     ex_a0, ex_b0, ex_a1, ex_b1;
  logic [rw-1:0]     ex_rd_num0, ex_rd_num1;
  logic [dw-1:0]     alu_result0, alu_result1, ex_result0;

  fetch_stage fetch (
    .clkrst_core_clk, .reset, .advance(issue), .flush, .new_pc,
    .ic_ready, .ic_packet, .ic_valid, .ic_addr,
    .bundle_valid, .bundle, .bundle_pc
  );

  lane_decode dec0 (
    .inst(bundle[dw-1:0]), .allow_branch(1'b1), .alu_op(dec_alu_op0),
    .rd_num(rd_num0), .rs_num(rs_num0), .rt_num(rt_num0), .uses_rt(uses_rt0),
    .rd_we(rd_we0), .imm(dec_imm0), .is_branch(dec_branch0)
  );

  lane_decode dec1 (
    .inst(bundle[core_pkg::bundle_w-1:dw]), .allow_branch(1'b0), .alu_op(dec_alu_op1),
    .rd_num(rd_num1), .rs_num(rs_num1), .rt_num(rt_num1), .uses_rt(uses_rt1),
    .rd_we(rd_we1), .imm(dec_imm1), .is_branch()
  );

  scoreboard sb (
    .clkrst_core_clk, .reset, .rs_num0, .rt_num0, .uses_rt0, .rs_num1, .rt_num1,
    .uses_rt1, .issue, .rd_num0, .rd_we0, .rd_num1, .rd_we1,
    .wb_rd_num0, .wb_we0, .wb_rd_num1, .wb_we1, .dep_stall
  );

  regfile regs (
    .clkrst_core_clk, .reset, .rs_num0, .rt_num0, .rs_num1, .rt_num1,
    .we0(wb_we0), .wd_num0(wb_rd_num0), .wd0(wb_rd_data0),
    .we1(wb_we1), .wd_num1(wb_rd_num1), .wd1(wb_rd_data1),
    .rs_data0, .rt_data0, .rs_data1, .rt_data1
  );

  assign issue = bundle_valid & ~dep_stall & ~flush;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset)
      ex_valid <= 1'b0;
    else
      ex_valid <= issue;                  // Bubble on stall or flush
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (issue) begin
      ex_pc      <= bundle_pc;
      ex_branch  <= dec_branch0;
      ex_alu_op0 <= dec_alu_op0;
      ex_a0      <= rs_data0;
      ex_b0      <= uses_rt0 ? rt_data0 : dec_imm0;
      ex_rd_num0 <= rd_num0;
      ex_rd_we0  <= rd_we0;
      ex_alu_op1 <= dec_alu_op1;
      ex_a1      <= rs_data1;
      ex_b1      <= uses_rt1 ? rt_data1 : dec_imm1;
      ex_rd_num1 <= rd_num1;
      ex_rd_we1  <= rd_we1;
    end
  end

  lane_alu alu0 (.alu_op(ex_alu_op0), .a(ex_a0), .b(ex_b0), .result(alu_result0));
  lane_alu alu1 (.alu_op(ex_alu_op1), .a(ex_a1), .b(ex_b1), .result(alu_result1));

  assign flush      = ex_valid & ex_branch;
  assign new_pc     = ex_pc + ex_b0[pw-1:0];       // PC-relative target
  assign link_pc    = ex_pc + 1'b1;
  assign ex_result0 = ex_branch ? {{(dw - pw){1'b0}}, link_pc} : alu_result0;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_we0   <= 1'b0;
      wb_we1   <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
      wb_we0   <= ex_valid & ex_rd_we0;
      wb_we1   <= ex_valid & ex_rd_we1;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    wb_pc       <= ex_pc;
    wb_rd_num0  <= ex_rd_num0;
    wb_rd_data0 <= ex_result0;
    wb_rd_num1  <= ex_rd_num1;
    wb_rd_data1 <= alu_result1;
  end

endmodule

// File: src/lane_alu.sv
module lane_alu (
  input  core_pkg::alu_op_t          alu_op,
  input  logic [core_pkg::data_w-1:0] a,
  input  logic [core_pkg::data_w-1:0] b,
  output logic [core_pkg::data_w-1:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];                  // Shift amount from the immediate

  always_comb begin
    case (alu_op)
      core_pkg::alu_add:
        result = a + b;
      core_pkg::alu_sub:
        result = a - b;
      core_pkg::alu_and:
        result = a & b;
      core_pkg::alu_or:
        result = a | b;
      core_pkg::alu_xor:
        result = a ^ b;
      core_pkg::alu_shl:
        result = a << shamt;
      default:
        result = '0;
    endcase
  end

endmodule

// File: src/regfile.sv
module regfile (
  input  logic                          clkrst_core_clk,
  input  logic                          reset,
  input  logic [core_pkg::reg_num_w-1:0] rs_num0,
  input  logic [core_pkg::reg_num_w-1:0] rt_num0,
  input  logic [core_pkg::reg_num_w-1:0] rs_num1,
  input  logic [core_pkg::reg_num_w-1:0] rt_num1,
  input  logic                          we0,
  input  logic [core_pkg::reg_num_w-1:0] wd_num0,
  input  logic [core_pkg::data_w-1:0]    wd0,
  input  logic                          we1,
  input  logic [core_pkg::reg_num_w-1:0] wd_num1,
  input  logic [core_pkg::data_w-1:0]    wd1,
  output logic [core_pkg::data_w-1:0]    rs_data0,
  output logic [core_pkg::data_w-1:0]    rt_data0,
  output logic [core_pkg::data_w-1:0]    rs_data1,
  output logic [core_pkg::data_w-1:0]    rt_data1
);

  logic [core_pkg::data_w-1:0] regs [core_pkg::num_regs];

  assign rs_data0 = regs[rs_num0];
  assign rt_data0 = regs[rt_num0];
  assign rs_data1 = regs[rs_num1];
  assign rt_data1 = regs[rt_num1];

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::num_regs; i++)
        regs[i] <= '0;
    end else begin
      if (we0)
        regs[wd_num0] <= wd0;
      if (we1)
        regs[wd_num1] <= wd1;             // Later assignment, lane 1 wins
    end
  end

endmodule

// File: src/scoreboard.sv
module scoreboard (
  input  logic                          clkrst_core_clk,
  input  logic                          reset,
  input  logic [core_pkg::reg_num_w-1:0] rs_num0,
  input  logic [core_pkg::reg_num_w-1:0] rt_num0,
  input  logic                          uses_rt0,
  input  logic [core_pkg::reg_num_w-1:0] rs_num1,
  input  logic [core_pkg::reg_num_w-1:0] rt_num1,
  input  logic                          uses_rt1,
  input  logic                          issue,
  input  logic [core_pkg::reg_num_w-1:0] rd_num0,
  input  logic                          rd_we0,
  input  logic [core_pkg::reg_num_w-1:0] rd_num1,
  input  logic                          rd_we1,
  input  logic [core_pkg::reg_num_w-1:0] wb_rd_num0,
  input  logic                          wb_we0,
  input  logic [core_pkg::reg_num_w-1:0] wb_rd_num1,
  input  logic                          wb_we1,
  output logic                          dep_stall
);

  logic [core_pkg::num_regs-1:0] pending;
  logic [core_pkg::num_regs-1:0] set_mask;
  logic [core_pkg::num_regs-1:0] clr_mask;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (issue && rd_we0) set_mask[rd_num0] = 1'b1;
    if (issue && rd_we1) set_mask[rd_num1] = 1'b1;
    if (wb_we0) clr_mask[wb_rd_num0] = 1'b1;
    if (wb_we1) clr_mask[wb_rd_num1] = 1'b1;
  end

  // No check between lanes of one bundle, both see the older state
  assign dep_stall = pending[rs_num0] | (uses_rt0 & pending[rt_num0]) |
                     pending[rs_num1] | (uses_rt1 & pending[rt_num1]);

  always_ff @(posedge clkrst_core_clk) begin
    if (reset)
      pending <= '0;
    else
      pending <= (pending & ~clr_mask) | set_mask; // Set beats clear
  end

endmodule

// File: src/lane_decode.sv
module lane_decode (
  input  logic [core_pkg::data_w-1:0]    inst,
  input  logic                          allow_branch,
  output core_pkg::alu_op_t             alu_op,
  output logic [core_pkg::reg_num_w-1:0] rd_num,
  output logic [core_pkg::reg_num_w-1:0] rs_num,
  output logic [core_pkg::reg_num_w-1:0] rt_num,
  output logic                          uses_rt,
  output logic                          rd_we,
  output logic [core_pkg::data_w-1:0]    imm,
  output logic                          is_branch
);

  core_pkg::instr_t                word;
  logic [core_pkg::opcode_w-1:0]   opcode;
  logic [core_pkg::data_w-1:0]     imm_ext;

  assign word    = inst;
  assign opcode  = word.reg_form.opcode;
  assign rd_num  = word.reg_form.rd;
  assign rs_num  = word.reg_form.rs;
  assign imm_ext = {{(core_pkg::data_w - core_pkg::imm_w){word.imm_form.imm[core_pkg::imm_w-1]}},
                    word.imm_form.imm};

  always_comb begin
    rt_num    = '0;
    uses_rt   = 1'b0;
    rd_we     = 1'b0;
    imm       = '0;
    is_branch = 1'b0;
    case (opcode)
      core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
      core_pkg::op_or, core_pkg::op_xor: begin
        rt_num  = word.reg_form.rt;      // Register view of the tail
        uses_rt = 1'b1;
        rd_we   = 1'b1;
      end
      core_pkg::op_addi, core_pkg::op_shli: begin
        imm   = imm_ext;                 // Immediate view of the tail
        rd_we = 1'b1;
      end
      core_pkg::op_br: begin
        imm       = imm_ext;
        rd_we     = allow_branch;        // Link write, nop in lane 1
        is_branch = allow_branch;
      end
      default: ;                         // nop and unknown opcodes
    endcase
  end

  always_comb begin
    case (opcode)
      core_pkg::op_sub:  alu_op = core_pkg::alu_sub;
      core_pkg::op_and:  alu_op = core_pkg::alu_and;
      core_pkg::op_or:   alu_op = core_pkg::alu_or;
      core_pkg::op_xor:  alu_op = core_pkg::alu_xor;
      core_pkg::op_shli: alu_op = core_pkg::alu_shl;
      default:           alu_op = core_pkg::alu_add;
    endcase
  end

endmodule

// File: src/fetch_stage.sv
module fetch_stage (
  input  logic                         clkrst_core_clk,
  input  logic                         reset,
  input  logic                         advance,
  input  logic                         flush,
  input  logic [core_pkg::pc_w-1:0]     new_pc,
  input  logic                         ic_ready,
  input  logic [core_pkg::bundle_w-1:0] ic_packet,
  output logic                         ic_valid,
  output logic [core_pkg::pc_w-1:0]     ic_addr,
  output logic                         bundle_valid,
  output logic [core_pkg::bundle_w-1:0] bundle,
  output logic [core_pkg::pc_w-1:0]     bundle_pc
);

  logic [core_pkg::pc_w-1:0] pc;        // Address of the next request
  logic                      discard;   // In-flight packet is stale
  logic                      accept;
  logic                      take;
  logic                      bundle_valid_next;
  logic                      start;

  assign accept = ic_valid & ic_ready;
  assign take   = accept & ~discard & ~flush;

  always_comb begin
    if (flush)
      bundle_valid_next = 1'b0;
    else if (take)
      bundle_valid_next = 1'b1;
    else if (advance)
      bundle_valid_next = 1'b0;
    else
      bundle_valid_next = bundle_valid;
  end

  // Only one request in flight, and only when its packet has a place to land
  assign start = (~ic_valid | accept) & ~bundle_valid_next;

  always_ff @(posedge clkrst_core_clk) begin
    if (reset) begin
      ic_valid     <= 1'b0;
      discard      <= 1'b0;
      bundle_valid <= 1'b0;
      pc           <= '0;
    end else begin
      ic_valid     <= start | (ic_valid & ~accept);
      bundle_valid <= bundle_valid_next;
      if (flush & ic_valid & ~accept)
        discard <= 1'b1;                  // Cannot cancel, drop on return
      else if (accept)
        discard <= 1'b0;
      if (flush)
        pc <= new_pc;
      else if (take)
        pc <= ic_addr + 1'b1;             // One bundle per packet
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (start)
      ic_addr <= flush ? new_pc : pc;     // Held until ic_ready
    if (take) begin
      bundle    <= ic_packet;
      bundle_pc <= ic_addr;
    end
  end

endmodule

// File: src/core_pkg.sv
package core_pkg;

  localparam int data_w    = 32;
  localparam int reg_num_w = 5;
  localparam int num_regs  = 32;
  localparam int num_lanes = 2;
  localparam int bundle_w  = data_w * num_lanes; // Lane 0 in the low word
  localparam int pc_w      = 16;                 // Bundle address, not byte address
  localparam int opcode_w  = 4;
  localparam int imm_w     = data_w - opcode_w - 2 * reg_num_w;

  localparam logic [opcode_w-1:0] op_nop  = 4'h0;
  localparam logic [opcode_w-1:0] op_add  = 4'h1;
  localparam logic [opcode_w-1:0] op_sub  = 4'h2;
  localparam logic [opcode_w-1:0] op_and  = 4'h3;
  localparam logic [opcode_w-1:0] op_or   = 4'h4;
  localparam logic [opcode_w-1:0] op_xor  = 4'h5;
  localparam logic [opcode_w-1:0] op_addi = 4'h6;
  localparam logic [opcode_w-1:0] op_shli = 4'h7;
  localparam logic [opcode_w-1:0] op_br   = 4'h8; // Lane 0 only

  typedef logic [2:0] alu_op_t;

  localparam alu_op_t alu_add = 3'd0;
  localparam alu_op_t alu_sub = 3'd1;
  localparam alu_op_t alu_and = 3'd2;
  localparam alu_op_t alu_or  = 3'd3;
  localparam alu_op_t alu_xor = 3'd4;
  localparam alu_op_t alu_shl = 3'd5;

  // Same head in both views, only the tail differs
  typedef union packed {
    struct packed {
      logic [opcode_w-1:0]              opcode;
      logic [reg_num_w-1:0]             rd;
      logic [reg_num_w-1:0]             rs;
      logic [reg_num_w-1:0]             rt;
      logic [imm_w-reg_num_w-1:0]       unused;
    } reg_form;
    struct packed {
      logic [opcode_w-1:0]              opcode;
      logic [reg_num_w-1:0]             rd;
      logic [reg_num_w-1:0]             rs;
      logic signed [imm_w-1:0]          imm;
    } imm_form;
  } instr_t;

endpackage
